/* include/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

`define DATA_W      32
`define REG_ADDR_W  5
`define QUEUE_DEPTH 4

// the data memory is word-addressed and its address wraps modulo this depth.
`define DMEM_WORDS  64

`define HALT_WORD   32'h0000000c // syscall with all other fields zero.

`endif

/* source/core_pkg.sv */
package core_pkg;

    // primary opcodes in bits 31:26.
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_addi  = 6'h08,
        op_addiu = 6'h09,
        op_slti  = 6'h0a,
        op_sltiu = 6'h0b,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_xori  = 6'h0e,
        op_lui   = 6'h0f,
        op_lb    = 6'h20,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_t;

    // function field of R-type words.
    typedef enum logic [5:0] {
        fn_sll     = 6'h00,
        fn_srl     = 6'h02,
        fn_sra     = 6'h03,
        fn_syscall = 6'h0c,
        fn_add     = 6'h20,
        fn_addu    = 6'h21,
        fn_sub     = 6'h22,
        fn_subu    = 6'h23,
        fn_and     = 6'h24,
        fn_or      = 6'h25,
        fn_xor     = 6'h26,
        fn_nor     = 6'h27,
        fn_slt     = 6'h2a,
        fn_sltu    = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or,
        alu_xor, alu_nor, alu_slt, alu_sltu,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_t;

    typedef enum logic [1:0] {
        res_alu,
        res_load_word,
        res_load_byte,
        res_none
    } result_src_t;

    typedef enum logic {
        st_running,
        st_halted
    } decode_state_t;

endpackage

/* source/instr_queue.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module instr_queue (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  logic [`DATA_W-1:0] in_inst,
    input  logic               pop,
    output logic [`DATA_W-1:0] inst_out,
    output logic               not_empty,
    output logic               credit_return
);
    localparam int PTR_W = $clog2(`QUEUE_DEPTH);

    logic [`DATA_W-1:0] slots [`QUEUE_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;

    always_ff @(posedge clk)
    begin
        if (in_valid)
            slots[wr_ptr] <= in_inst;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end
        else
        begin
            if (in_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count         <= count + {{PTR_W{1'b0}}, in_valid} - {{PTR_W{1'b0}}, pop};
            credit_return <= pop; // one credit back per word taken.
        end
    end

    assign inst_out  = slots[rd_ptr];
    assign not_empty = (count != '0);

    // the sender may only push while it holds a credit, so a full queue sees no push.
    assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> count != `QUEUE_DEPTH);
    assert property (@(posedge clk) disable iff (!rst_n) pop |-> not_empty);

endmodule

/* source/register_file.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module register_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`REG_ADDR_W-1:0] rs_num,
    input  logic [`REG_ADDR_W-1:0] rt_num,
    output logic [`DATA_W-1:0]     rs_data,
    output logic [`DATA_W-1:0]     rt_data,
    input  logic                   wr_en,
    input  logic [`REG_ADDR_W-1:0] wr_num,
    input  logic [`DATA_W-1:0]     wr_data
);
    localparam int NUM_REGS = 1 << `REG_ADDR_W;

    logic [`DATA_W-1:0] regs [NUM_REGS];

    // a write in flight is visible to the reader in the same cycle.
    function automatic logic [`DATA_W-1:0] read_port(input logic [`REG_ADDR_W-1:0] num);
        if (num == '0)
            return '0;
        if (wr_en && wr_num == num)
            return wr_data;
        return regs[num];
    endfunction

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wr_en && wr_num != '0)
            regs[wr_num] <= wr_data;
    end

    always_comb
        rs_data = read_port(rs_num);

    always_comb
        rt_data = read_port(rt_num);

endmodule

/* source/decode_stage.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module decode_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   not_empty,
    input  logic [`DATA_W-1:0]     inst_in,
    output logic                   pop,
    input  logic                   wb_valid,
    input  logic [`REG_ADDR_W-1:0] wb_num,
    input  logic [`DATA_W-1:0]     wb_data,
    output logic                   ex_valid,
    output core_pkg::alu_op_t      ex_alu_op,
    output logic [`DATA_W-1:0]     ex_src_a,
    output logic [`DATA_W-1:0]     ex_src_b,
    output logic [4:0]             ex_shamt,
    output core_pkg::result_src_t  ex_result_src,
    output logic                   ex_store,
    output logic [`DATA_W-1:0]     ex_store_data,
    output logic [`REG_ADDR_W-1:0] ex_dest,
    output logic                   halted
);
    import core_pkg::*;

    localparam int NUM_REGS = 1 << `REG_ADDR_W;

    decode_state_t          state;
    logic [`DATA_W-1:0]     inst_q;
    logic                   inst_valid;
    logic [NUM_REGS-1:0]    pending;   // destinations of issued, unretired writes.
    opcode_t                opcode;
    funct_t                 funct;
    logic [`REG_ADDR_W-1:0] rs_num;
    logic [`REG_ADDR_W-1:0] rt_num;
    logic [`REG_ADDR_W-1:0] dest;
    logic [`DATA_W-1:0]     rs_data;
    logic [`DATA_W-1:0]     rt_data;
    logic [`DATA_W-1:0]     imm_ext;
    alu_op_t                alu_op;
    result_src_t            result_src;
    logic                   is_rtype;
    logic                   zero_ext;
    logic                   uses_rs;
    logic                   uses_rt;
    logic                   writes;
    logic                   rs_busy;
    logic                   rt_busy;
    logic                   issue;

    register_file u_register_file (
        .clk, .rst_n,
        .rs_num, .rt_num, .rs_data, .rt_data,
        .wr_en(wb_valid), .wr_num(wb_num), .wr_data(wb_data)
    );

    assign opcode   = opcode_t'(inst_q[31:26]);
    assign funct    = funct_t'(inst_q[5:0]);
    assign rs_num   = inst_q[25:21];
    assign rt_num   = inst_q[20:16];
    assign is_rtype = (opcode == op_rtype);
    assign dest     = is_rtype ? inst_q[15:11] : rt_num;
    assign zero_ext = opcode inside {op_andi, op_ori, op_xori};
    assign imm_ext  = zero_ext ? {16'h0000, inst_q[15:0]} : {{16{inst_q[15]}}, inst_q[15:0]};

    always_comb
    begin
        alu_op     = alu_add;
        result_src = res_alu;
        case (opcode)
            op_rtype:
            begin
                case (funct)
                    fn_sll:          alu_op = alu_sll;
                    fn_srl:          alu_op = alu_srl;
                    fn_sra:          alu_op = alu_sra;
                    fn_add, fn_addu: alu_op = alu_add;
                    fn_sub, fn_subu: alu_op = alu_sub;
                    fn_and:          alu_op = alu_and;
                    fn_or:           alu_op = alu_or;
                    fn_xor:          alu_op = alu_xor;
                    fn_nor:          alu_op = alu_nor;
                    fn_slt:          alu_op = alu_slt;
                    fn_sltu:         alu_op = alu_sltu;
                    default:         result_src = res_none;
                endcase
            end
            op_addi, op_addiu: alu_op = alu_add;
            op_slti:           alu_op = alu_slt;
            op_sltiu:          alu_op = alu_sltu;
            op_andi:           alu_op = alu_and;
            op_ori:            alu_op = alu_or;
            op_xori:           alu_op = alu_xor;
            op_lui:            alu_op = alu_lui;
            op_lb:             result_src = res_load_byte;
            op_lw:             result_src = res_load_word;
            default:           result_src = res_none; // sw and unknown words write nothing.
        endcase
    end

    // shifts and lui take no rs operand; only R-type and sw read rt.
    assign uses_rs = !(alu_op inside {alu_sll, alu_srl, alu_sra, alu_lui});
    assign uses_rt = is_rtype || (opcode == op_sw);
    assign writes  = (result_src != res_none) && (dest != '0);

    // a retiring write clears its bit in time for the reader to issue.
    assign rs_busy = uses_rs && pending[rs_num] && !(wb_valid && wb_num == rs_num);
    assign rt_busy = uses_rt && pending[rt_num] && !(wb_valid && wb_num == rt_num);
    assign issue   = inst_valid && !rs_busy && !rt_busy;
    assign pop     = not_empty && (state == st_running) && (!inst_valid || issue);
    assign halted  = (state == st_halted);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state      <= st_running;
            inst_valid <= 1'b0;
            pending    <= '0;
            ex_valid   <= 1'b0;
        end
        else
        begin
            if (pop && inst_in == `HALT_WORD)
                state <= st_halted;
            if (pop)
                inst_valid <= (inst_in != `HALT_WORD);
            else if (issue)
                inst_valid <= 1'b0;
            if (wb_valid)
                pending[wb_num] <= 1'b0;
            if (issue && writes)
                pending[dest] <= 1'b1; // a new writer of the same number wins.
            ex_valid <= issue;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
            inst_q <= inst_in;
        if (issue)
        begin
            ex_alu_op     <= alu_op;
            ex_src_a      <= rs_data;
            ex_src_b      <= is_rtype ? rt_data : imm_ext;
            ex_shamt      <= inst_q[10:6];
            ex_result_src <= result_src;
            ex_store      <= (opcode == op_sw);
            ex_store_data <= rt_data;
            ex_dest       <= dest;
        end
    end

    // nothing is popped or left waiting to issue once the core has halted.
    assert property (@(posedge clk) disable iff (!rst_n)
                     state == st_halted |-> !pop && !inst_valid);

endmodule

/* source/execute_stage.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module execute_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ex_valid,
    input  core_pkg::alu_op_t      ex_alu_op,
    input  logic [`DATA_W-1:0]     ex_src_a,
    input  logic [`DATA_W-1:0]     ex_src_b,
    input  logic [4:0]             ex_shamt,
    input  core_pkg::result_src_t  ex_result_src,
    input  logic                   ex_store,
    input  logic [`DATA_W-1:0]     ex_store_data,
    input  logic [`REG_ADDR_W-1:0] ex_dest,
    output logic                   rs_valid,
    output logic [`DATA_W-1:0]     rs_value,
    output core_pkg::result_src_t  rs_result_src,
    output logic                   rs_store,
    output logic [`DATA_W-1:0]     rs_store_data,
    output logic [`REG_ADDR_W-1:0] rs_dest
);
    import core_pkg::*;

    logic [`DATA_W-1:0] alu_result;

    // the signed and unsigned adds share one wrapping adder.
    always_comb
    begin
        case (ex_alu_op)
            alu_add:  alu_result = ex_src_a + ex_src_b;
            alu_sub:  alu_result = ex_src_a - ex_src_b;
            alu_and:  alu_result = ex_src_a & ex_src_b;
            alu_or:   alu_result = ex_src_a | ex_src_b;
            alu_xor:  alu_result = ex_src_a ^ ex_src_b;
            alu_nor:  alu_result = ~(ex_src_a | ex_src_b);
            alu_slt:  alu_result = {{(`DATA_W-1){1'b0}}, $signed(ex_src_a) < $signed(ex_src_b)};
            alu_sltu: alu_result = {{(`DATA_W-1){1'b0}}, ex_src_a < ex_src_b};
            alu_sll:  alu_result = ex_src_b << ex_shamt;
            alu_srl:  alu_result = ex_src_b >> ex_shamt;
            alu_sra:  alu_result = $signed(ex_src_b) >>> ex_shamt;
            alu_lui:  alu_result = {ex_src_b[15:0], 16'h0000};
            default:  alu_result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rs_valid <= 1'b0;
        else
            rs_valid <= ex_valid;
    end

    // loads and stores carry their address in rs_value.
    always_ff @(posedge clk)
    begin
        rs_value      <= alu_result;
        rs_result_src <= ex_result_src;
        rs_store      <= ex_store;
        rs_store_data <= ex_store_data;
        rs_dest       <= ex_dest;
    end

endmodule

/* source/result_stage.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module result_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rs_valid,
    input  logic [`DATA_W-1:0]     rs_value,
    input  core_pkg::result_src_t  rs_result_src,
    input  logic                   rs_store,
    input  logic [`DATA_W-1:0]     rs_store_data,
    input  logic [`REG_ADDR_W-1:0] rs_dest,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_num,
    output logic [`DATA_W-1:0]     wb_data,
    output logic                   mem_we,
    output logic [`DATA_W-1:0]     mem_addr,
    output logic [`DATA_W-1:0]     mem_data
);
    import core_pkg::*;

    localparam int DMEM_AW = $clog2(`DMEM_WORDS);

    logic [`DATA_W-1:0] dmem [`DMEM_WORDS];
    logic [DMEM_AW-1:0] word_idx;
    logic [`DATA_W-1:0] load_word;
    logic [7:0]         load_byte;
    logic [`DATA_W-1:0] wr_value;

    assign word_idx  = rs_value[DMEM_AW+1:2];
    assign load_word = dmem[word_idx];

    // big-endian words, so byte 0 is the top byte.
    always_comb
    begin
        case (rs_value[1:0])
            2'd0:    load_byte = load_word[31:24];
            2'd1:    load_byte = load_word[23:16];
            2'd2:    load_byte = load_word[15:8];
            default: load_byte = load_word[7:0];
        endcase
    end

    always_comb
    begin
        case (rs_result_src)
            res_load_word: wr_value = load_word;
            res_load_byte: wr_value = {{(`DATA_W-8){load_byte[7]}}, load_byte};
            default:       wr_value = rs_value;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `DMEM_WORDS; i++)
                dmem[i] <= '0;
        end
        else if (rs_valid && rs_store)
            dmem[word_idx] <= rs_store_data;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wb_valid <= 1'b0;
            mem_we   <= 1'b0;
        end
        else
        begin
            wb_valid <= rs_valid && (rs_result_src != res_none) && (rs_dest != '0);
            mem_we   <= rs_valid && rs_store;
        end
    end

    always_ff @(posedge clk)
    begin
        wb_num   <= rs_dest;
        wb_data  <= wr_value;
        mem_addr <= rs_value;
        mem_data <= rs_store_data;
    end

    // decode never marks a store as a register writer.
    assert property (@(posedge clk) disable iff (!rst_n) !(mem_we && wb_valid));

endmodule

/* source/mips_core_top.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module mips_core_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic [`DATA_W-1:0]     in_inst,
    output logic                   credit_return,
    output logic                   wb_valid,
    output logic [`REG_ADDR_W-1:0] wb_num,
    output logic [`DATA_W-1:0]     wb_data,
    output logic                   mem_we,
    output logic [`DATA_W-1:0]     mem_addr,
    output logic [`DATA_W-1:0]     mem_data,
    output logic                   halted
);
    import core_pkg::*;

    logic [`DATA_W-1:0]     queue_inst;
    logic                   not_empty;
    logic                   pop;
    logic                   ex_valid;
    alu_op_t                ex_alu_op;
    logic [`DATA_W-1:0]     ex_src_a;
    logic [`DATA_W-1:0]     ex_src_b;
    logic [4:0]             ex_shamt;
    result_src_t            ex_result_src;
    logic                   ex_store;
    logic [`DATA_W-1:0]     ex_store_data;
    logic [`REG_ADDR_W-1:0] ex_dest;
    logic                   rs_valid;
    logic [`DATA_W-1:0]     rs_value;
    result_src_t            rs_result_src;
    logic                   rs_store;
    logic [`DATA_W-1:0]     rs_store_data;
    logic [`REG_ADDR_W-1:0] rs_dest;

    instr_queue u_instr_queue (
        .clk, .rst_n, .in_valid, .in_inst, .pop,
        .inst_out(queue_inst), .not_empty, .credit_return
    );

    decode_stage u_decode_stage (
        .clk, .rst_n, .not_empty, .inst_in(queue_inst), .pop,
        .wb_valid, .wb_num, .wb_data,
        .ex_valid, .ex_alu_op, .ex_src_a, .ex_src_b, .ex_shamt,
        .ex_result_src, .ex_store, .ex_store_data, .ex_dest,
        .halted
    );

    execute_stage u_execute_stage (
        .clk, .rst_n,
        .ex_valid, .ex_alu_op, .ex_src_a, .ex_src_b, .ex_shamt,
        .ex_result_src, .ex_store, .ex_store_data, .ex_dest,
        .rs_valid, .rs_value, .rs_result_src, .rs_store, .rs_store_data, .rs_dest
    );

    result_stage u_result_stage (
        .clk, .rst_n,
        .rs_valid, .rs_value, .rs_result_src, .rs_store, .rs_store_data, .rs_dest,
        .wb_valid, .wb_num, .wb_data,
        .mem_we, .mem_addr, .mem_data
    );

endmodule

/* testbench/tb_checker.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module tb_checker #(
    parameter int NUM_ROWS = 1
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  logic                      credit_return,
    input  logic                      wb_valid,
    input  logic [`REG_ADDR_W-1:0]    wb_num,
    input  logic [`DATA_W-1:0]        wb_data,
    input  logic                      mem_we,
    input  logic [`DATA_W-1:0]        mem_addr,
    input  logic [`DATA_W-1:0]        mem_data,
    input  logic                      halted,
    input  logic [NUM_ROWS-1:0][1:0]  exp_kind,
    input  logic [NUM_ROWS-1:0][31:0] exp_key,
    input  logic [NUM_ROWS-1:0][31:0] exp_value,
    output int                        value_errors,
    output int                        protocol_errors,
    output logic                      all_seen
);
    localparam logic [1:0] KIND_NONE  = 2'd0;
    localparam logic [1:0] KIND_WB    = 2'd1;
    localparam logic [1:0] KIND_STORE = 2'd2;

    int   row;         // first table row not matched yet.
    int   outstanding; // words pushed whose credit has not come back.
    logic halted_q;

    // results appear in program order, so rows without a result are skipped.
    function automatic int next_result(input int from);
        int r;
        r = from;
        while (r < NUM_ROWS && exp_kind[r] == KIND_NONE)
            r++;
        return r;
    endfunction

    task automatic match_event(input logic [1:0] kind, input string name,
                               input logic [31:0] key, input logic [31:0] value);
        int r;
        r = next_result(row);
        if (r >= NUM_ROWS)
        begin
            protocol_errors++;
            $display("unexpected %s 0x%0h after the last expected result", name, key);
        end
        else if (exp_kind[r] != kind)
        begin
            protocol_errors++;
            $display("%s 0x%0h arrived where table row %0d expects another kind of result",
                     name, key, r);
            row = r + 1;
        end
        else
        begin
            if (key != exp_key[r] || value != exp_value[r])
            begin
                value_errors++;
                $display("** Error at %0t: %s 0x%0h = %h, expected 0x%0h = %h",
                         $time, name, key, value, exp_key[r], exp_value[r]);
            end
            row = r + 1;
        end
    endtask

    always_comb
        all_seen = (next_result(row) >= NUM_ROWS);

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            row             = 0;
            outstanding     = 0;
            halted_q        = 1'b0;
            value_errors    = 0;
            protocol_errors = 0;
        end
        else
        begin
            outstanding = outstanding + int'(in_valid) - int'(credit_return);
            if (outstanding > `QUEUE_DEPTH)
            begin
                protocol_errors++;
                $display("sender holds %0d words in flight, more than the queue has room for",
                         outstanding);
            end
            if (outstanding < 0)
            begin
                protocol_errors++;
                $display("a credit came back for a word that was never sent");
            end
            if (halted_q && !halted)
            begin
                protocol_errors++;
                $display("halted fell again after the core had halted");
            end
            if (halted_q && credit_return)
            begin
                protocol_errors++;
                $display("a credit came back after the core had halted");
            end
            halted_q = halted;
            if (wb_valid)
                match_event(KIND_WB, "writeback to register", 32'(wb_num), wb_data);
            if (mem_we)
                match_event(KIND_STORE, "store to address", mem_addr, mem_data);
        end
    end

endmodule

/* testbench/tb_top.sv */
`timescale 1ns/1ns
`include "core_macros.svh"

module tb_top;
    import core_pkg::*;

    localparam int NUM_ROWS     = 29;
    localparam int BURST_ROWS   = 12; // these rows go out as fast as credits allow.
    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_CYCLES = 8;
    localparam int MAX_CYCLES   = 15 * NUM_ROWS;
    localparam int KIND_NONE    = 0;
    localparam int KIND_WB      = 1;
    localparam int KIND_STORE   = 2;

    logic                      clk;
    logic                      rst_n;
    logic                      in_valid;
    logic [`DATA_W-1:0]        in_inst;
    logic                      credit_return;
    logic                      wb_valid;
    logic [`REG_ADDR_W-1:0]    wb_num;
    logic [`DATA_W-1:0]        wb_data;
    logic                      mem_we;
    logic [`DATA_W-1:0]        mem_addr;
    logic [`DATA_W-1:0]        mem_data;
    logic                      halted;
    logic [`DATA_W-1:0]        inst_words [NUM_ROWS];
    logic [NUM_ROWS-1:0][1:0]  exp_kind;
    logic [NUM_ROWS-1:0][31:0] exp_key;   // register number or store address.
    logic [NUM_ROWS-1:0][31:0] exp_value;
    int                        row_count;
    int                        value_errors;
    int                        protocol_errors;
    logic                      all_seen;
    int                        cycle_count = 0;

    mips_core_top u_mips_core_top (
        .clk, .rst_n, .in_valid, .in_inst, .credit_return,
        .wb_valid, .wb_num, .wb_data, .mem_we, .mem_addr, .mem_data, .halted
    );

    tb_checker #(.NUM_ROWS(NUM_ROWS)) u_checker (
        .clk, .rst_n, .in_valid, .credit_return,
        .wb_valid, .wb_num, .wb_data, .mem_we, .mem_addr, .mem_data, .halted,
        .exp_kind, .exp_key, .exp_value, .value_errors, .protocol_errors, .all_seen
    );

    function automatic logic [31:0] encode_r(input int rs, input int rt, input int rd,
                                             input int shamt, input funct_t fn);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), fn};
    endfunction

    function automatic logic [31:0] encode_i(input opcode_t op, input int rs, input int rt,
                                             input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [15:0] next_lfsr(input logic [15:0] state);
        if (state[0])
            return (state >> 1) ^ 16'hb400;
        return state >> 1;
    endfunction

    task automatic add_row(input logic [31:0] word, input int kind, input int key,
                           input logic [31:0] value);
        inst_words[row_count] = word;
        exp_kind[row_count]   = 2'(kind);
        exp_key[row_count]    = 32'(key);
        exp_value[row_count]  = value;
        row_count++;
    endtask

    // r1 = -10 and r2 = 7 feed most of the later rows.
    task automatic build_table();
        add_row(encode_i(op_addi, 0, 1, 16'hfff6), KIND_WB, 1, 32'hfffffff6);
        add_row(encode_i(op_addi, 0, 2, 16'h0007), KIND_WB, 2, 32'h00000007);
        add_row(encode_r(1, 2, 3, 0, fn_add), KIND_WB, 3, 32'hfffffffd);
        add_row(encode_r(2, 1, 4, 0, fn_sub), KIND_WB, 4, 32'h00000011);
        add_row(encode_r(1, 2, 5, 0, fn_and), KIND_WB, 5, 32'h00000006);
        add_row(encode_r(1, 2, 6, 0, fn_or), KIND_WB, 6, 32'hfffffff7);
        add_row(encode_r(1, 2, 7, 0, fn_xor), KIND_WB, 7, 32'hfffffff1);
        add_row(encode_r(1, 2, 8, 0, fn_nor), KIND_WB, 8, 32'h00000008);
        add_row(encode_r(1, 2, 9, 0, fn_slt), KIND_WB, 9, 32'h00000001);
        add_row(encode_r(1, 2, 10, 0, fn_sltu), KIND_WB, 10, 32'h00000000);
        add_row(encode_i(op_slti, 1, 11, 16'hfffb), KIND_WB, 11, 32'h00000001);
        add_row(encode_i(op_andi, 1, 12, 16'hff0f), KIND_WB, 12, 32'h0000ff06);
        add_row(encode_i(op_ori, 0, 13, 16'h8001), KIND_WB, 13, 32'h00008001);
        add_row(encode_i(op_xori, 1, 14, 16'hffff), KIND_WB, 14, 32'hffff0009);
        add_row(encode_i(op_lui, 0, 15, 16'h8123), KIND_WB, 15, 32'h81230000);
        add_row(encode_r(0, 15, 16, 4, fn_sra), KIND_WB, 16, 32'hf8123000);
        add_row(encode_r(0, 15, 17, 8, fn_srl), KIND_WB, 17, 32'h00812300);
        add_row(encode_r(0, 2, 18, 28, fn_sll), KIND_WB, 18, 32'h70000000);
        add_row(encode_r(1, 2, 0, 0, fn_addu), KIND_NONE, 0, 32'h0); // r0 keeps zero.
        add_row(encode_r(2, 0, 19, 0, fn_sub), KIND_WB, 19, 32'h00000007);
        add_row(encode_i(op_ori, 15, 20, 16'h4567), KIND_WB, 20, 32'h81234567);
        add_row(encode_i(op_sw, 2, 20, 16'h0009), KIND_STORE, 32'h10, 32'h81234567);
        add_row(encode_i(op_lw, 0, 21, 16'h0010), KIND_WB, 21, 32'h81234567);
        add_row(encode_i(op_lb, 0, 22, 16'h0010), KIND_WB, 22, 32'hffffff81);
        add_row(encode_i(op_lb, 0, 23, 16'h0013), KIND_WB, 23, 32'h00000067);
        add_row(encode_i(op_sw, 0, 22, 16'h0014), KIND_STORE, 32'h14, 32'hffffff81);
        add_row(`HALT_WORD, KIND_NONE, 0, 32'h0);
        add_row(encode_i(op_addi, 0, 25, 16'h0001), KIND_NONE, 0, 32'h0); // behind the halt.
        add_row(encode_i(op_sw, 0, 2, 16'h0000), KIND_NONE, 0, 32'h0);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        int          sent;
        int          credits;
        logic        send;
        logic [15:0] lfsr;
        sent      = 0;
        credits   = `QUEUE_DEPTH;
        lfsr      = 16'd25;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_inst   = '0;
        row_count = 0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        while (sent < NUM_ROWS)
        begin
            @(negedge clk);
            if (credit_return)
                credits++;
            send = (credits > 0);
            if (send && sent >= BURST_ROWS)
            begin
                send = lfsr[0]; // a zero bit leaves a gap this cycle.
                lfsr = next_lfsr(lfsr);
            end
            @(posedge clk);
            in_valid <= send;
            if (send)
            begin
                in_inst <= inst_words[sent];
                sent++;
                credits--;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        while (!halted)
            @(negedge clk);
        while (!all_seen)
            @(negedge clk);
        repeat (DRAIN_CYCLES) @(negedge clk); // words behind the halt must stay silent.
        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            if (halted)
                $display("timeout after %0d cycles, expected results are missing", cycle_count);
            else
                $display("timeout after %0d cycles, the core never halted", cycle_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

endmodule

/* all.f */
+incdir+include
source/core_pkg.sv
source/instr_queue.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/mips_core_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -f all.f --top-module tb_top -Mdir obj_dir; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_top > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if ! grep -qx "TESTBENCH PASSED" "$LOG"; then
    echo "pass message not found in $LOG"
    exit 1
fi

exit 0
